//--- Bender.yml
package:
  name: evict_mon

sources:
  - hw/evict_cmd_pkg.sv
  - hw/evict_err_pkg.sv
  - hw/evict_cmd_decode.sv
  - hw/evict_cmd_queue.sv
  - hw/evict_beat_tracker.sv
  - hw/evict_bypass_buffer.sv
  - hw/evict_mon_top.sv
  - target: test
    files:
      - dv/evict_mon_chk.sv
      - dv/evict_mon_tb.sv

//--- dv/evict_mon_chk.sv
`timescale 1ns/1ps
`default_nettype none

module evict_mon_chk import evict_err_pkg::*; #(
   parameter int CMD_DEPTH = 8,
   parameter int PTR_W     = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1
) (
   input wire                           clk,
   input wire                           reset_n,
   input wire                           empty,
   input wire [$clog2(CMD_DEPTH+1)-1:0] count,
   input wire [PTR_W-1:0]               wr_ptr,
   input wire [PTR_W-1:0]               rd_ptr,
   input wire                           push_1,
   input wire                           push_2,
   input wire                           pop,
   input wire [ERR_N-1:0]               err_flags
);

   // an empty queue has both pointers on the same slot
   assert property (@(posedge clk) disable iff (!reset_n) empty |-> (wr_ptr == rd_ptr))
      else $error("command queue is empty while it holds entries");

   assert property (@(posedge clk) disable iff (!reset_n) count <= CMD_DEPTH)
      else $error("command queue holds more entries than its depth");

   // flags are sticky until reset
   assert property (@(posedge clk) disable iff (!reset_n) ($past(err_flags) & ~err_flags) == '0)
      else $error("an error flag cleared without reset");

   // a lone pop retires exactly one entry and cannot underflow the count
   assert property (@(posedge clk) disable iff (!reset_n)
                    (pop && !push_1 && !push_2) |=> (count == $past(count) - 1'b1))
      else $error("command queue pop did not retire exactly one entry");

endmodule

bind evict_mon_top evict_mon_chk #(.CMD_DEPTH(CMD_DEPTH)) chk0 (
   .clk      (clk),
   .reset_n  (reset_n),
   .empty    (empty),
   .count    (u_queue.count_q),
   .wr_ptr   (u_queue.wr_ptr_q),
   .rd_ptr   (u_queue.rd_ptr_q),
   .push_1   (push_1),
   .push_2   (push_2),
   .pop      (pop),
   .err_flags(err_flags)
);

`default_nettype wire

//--- dv/evict_mon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module evict_mon_tb
   import evict_cmd_pkg::*, evict_err_pkg::*;
();

   localparam int DATA_W         = 64;
   localparam int BE_W           = DATA_W / 8;
   localparam int BURST_LEN_W    = 2;
   localparam int CMD_DEPTH      = 8;
   localparam int BYP_DEPTH      = 4;
   // longest run is well under 1000 cycles
   localparam int TIMEOUT_CYCLES = 3000;

   // command word: valid, evict_valid, read, write, port_sel, bypass, allocate,
   // nack, nack_uce, nack_ce, nack_no_allocate, burst_len[1:0]
   localparam logic [12:0] CMD_EVICT  = 13'b1_1_1_0_0_0_1_0_0_0_0_00;
   localparam logic [12:0] CMD_DOUBLE = 13'b1_1_1_0_1_1_0_0_0_0_0_00;
   localparam logic [12:0] CMD_WT     = 13'b1_0_0_1_1_1_0_0_0_0_0_00;
   localparam logic [12:0] CMD_BYP    = 13'b1_0_0_0_1_1_0_0_0_0_0_00;
   localparam logic [12:0] CMD_RD     = 13'b1_0_1_0_1_0_1_0_0_0_0_00;

   localparam logic [1:0] EV_CMD  = 2'd0;
   localparam logic [1:0] EV_WR   = 2'd1;
   localparam logic [1:0] EV_BEAT = 2'd2;

   typedef struct packed {
      logic [1:0]        kind;
      logic [12:0]       cmd;
      logic [DATA_W-1:0] data;
      logic [BE_W-1:0]   be;
      logic              last;
      logic              bad_hold;
   } ev_t;

   logic clk;
   logic reset_n;
   logic cache_valid_p2, cache_evict_valid_p2, ctrl_op_read_data_p2, ctrl_op_write_data_p2;
   logic ctrl_op_port_sel_p2, ctrl_op_bypass_p2, ctrl_op_allocate_p2;
   logic [BURST_LEN_W-1:0] ctrl_op_burst_len_p2;
   logic cache_nack_p2, cache_nack_uce_p2, cache_nack_ce_p2, cache_nack_no_allocate_p2;
   logic ctrl_wr_valid, cache_wr_ready, ctrl_wr_last, ctrl_wr_bypass;
   logic [DATA_W-1:0] ctrl_wr_data;
   logic [BE_W-1:0]   ctrl_wr_byte_en;
   logic cache_evict_valid, ctrl_evict_ready, cache_evict_last;
   logic [DATA_W-1:0] cache_evict_data;
   logic [BE_W-1:0]   cache_evict_byteen;
   logic [ERR_N-1:0]  err_flags;

   integer seed;
   int     cycle_cnt;
   ev_t    events [$];
   event   test_end;
   event   check_done;

   evict_mon_top #(
      .DATA_W     (DATA_W),
      .BURST_LEN_W(BURST_LEN_W),
      .CMD_DEPTH  (CMD_DEPTH),
      .BYP_DEPTH  (BYP_DEPTH)
   ) dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $fatal(1, "timeout");
      end
   end

   function automatic void log_event(input logic [1:0] kind, input logic [12:0] cmd,
                                     input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be,
                                     input logic last, input logic bad_hold);
      ev_t e;
      e.kind     = kind;
      e.cmd      = cmd;
      e.data     = data;
      e.be       = be;
      e.last     = last;
      e.bad_hold = bad_hold;
      events.push_back(e);
   endfunction

   // replays the recorded events through the decode, beat and hold rules
   function automatic logic [ERR_N-1:0] expected_flags();
      logic [ERR_N-1:0]       flags;
      logic [CLS_W-1:0]       q_cls [$];
      int                     q_len [$];
      logic [DATA_W+BE_W:0]   wq [$];
      logic [CLS_W-1:0]       new_cls [$];
      logic [12:0]            c;
      int                     cnt;
      int                     idx;
      flags = '0;
      cnt = 0;
      foreach (events[i]) begin
         c = events[i].cmd;
         new_cls.delete();
         if (events[i].kind == EV_CMD) begin
            if (c[12] && !c[5] && !c[4] && !c[3] && !(c[2] && c[6])) begin
               if (c[10] && c[11]) begin
                  new_cls.push_back(CLS_EVICTION);
                  if (!c[9] && c[8] && c[7]) new_cls.push_back(CLS_BYPASS_ONLY);
               end else if (!c[10] && c[9] && c[8] && c[7]) begin
                  new_cls.push_back(CLS_WR_THROUGH);
               end else if (!c[10] && !c[9] && c[8] && c[7]) begin
                  new_cls.push_back(CLS_BYPASS_ONLY);
               end else if (c[10] && !c[9] && c[8] && !c[7] && !c[11]) begin
                  new_cls.push_back(CLS_RD_ONLY);
               end
            end
            foreach (new_cls[j]) begin
               if (q_cls.size() == CMD_DEPTH) begin
                  flags[ERR_OVERFLOW] = 1'b1;
               end else begin
                  q_cls.push_back(new_cls[j]);
                  q_len.push_back(int'(c[1:0]));
               end
            end
         end else if (events[i].kind == EV_WR) begin
            if (wq.size() < BYP_DEPTH) begin
               wq.push_back({events[i].data, events[i].be, events[i].last});
            end
         end else begin
            if (events[i].bad_hold) flags[ERR_HOLD] = 1'b1;
            if (q_cls.size() == 0) begin
               flags[ERR_UNDERFLOW] = 1'b1;
            end else begin
               idx = (q_cls[0] == CLS_EVICTION) ? LINE_BEATS - 1 : q_len[0];
               if (events[i].last != (cnt == idx)) flags[ERR_LAST] = 1'b1;
               if (q_cls[0] != CLS_BYPASS_ONLY && events[i].be != '1) flags[ERR_BYTEEN] = 1'b1;
               if (q_cls[0] == CLS_BYPASS_ONLY) begin
                  if (wq.size() == 0) begin
                     flags[ERR_BYPASS] = 1'b1;
                  end else begin
                     if (wq.pop_front() != {events[i].data, events[i].be, events[i].last})
                        flags[ERR_BYPASS] = 1'b1;
                  end
               end
               if (cnt == idx || events[i].last) begin
                  cnt = 0;
                  void'(q_cls.pop_front());
                  void'(q_len.pop_front());
               end else begin
                  cnt++;
               end
            end
         end
      end
      return flags;
   endfunction

   task automatic check_flags(input logic [ERR_N-1:0] got, input logic [ERR_N-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: err_flags %b, expected %b", $time, got, exp);
         $display("Testbench failed");
         $fatal(1, "error flags differ from the reference");
      end
   endtask

   initial begin
      forever begin
         @(test_end);
         repeat (2) @(posedge clk);
         @(negedge clk);
         check_flags(err_flags, expected_flags());
         -> check_done;
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      reset_n <= 1'b0;
      repeat (8) @(posedge clk);
      reset_n <= 1'b1;
      events.delete();
   endtask

   task automatic send_cmd(input logic [12:0] c, input logic [1:0] len);
      @(posedge clk);
      {cache_valid_p2, cache_evict_valid_p2, ctrl_op_read_data_p2, ctrl_op_write_data_p2,
       ctrl_op_port_sel_p2, ctrl_op_bypass_p2, ctrl_op_allocate_p2, cache_nack_p2,
       cache_nack_uce_p2, cache_nack_ce_p2, cache_nack_no_allocate_p2} <= c[12:2];
      ctrl_op_burst_len_p2 <= len;
      @(posedge clk);
      cache_valid_p2 <= 1'b0;
      log_event(EV_CMD, {c[12:2], len}, '0, '0, 1'b0, 1'b0);
   endtask

   task automatic send_wr(input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be,
                          input logic last);
      @(posedge clk);
      ctrl_wr_valid   <= 1'b1;
      ctrl_wr_data    <= d;
      ctrl_wr_byte_en <= be;
      ctrl_wr_last    <= last;
      @(posedge clk);
      ctrl_wr_valid <= 1'b0;
      log_event(EV_WR, '0, d, be, last, 1'b0);
   endtask

   // optional stall cycles, the first of which may corrupt the held data
   task automatic send_beat(input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be,
                            input logic last, input int nstall, input logic change);
      @(posedge clk);
      cache_evict_valid  <= 1'b1;
      cache_evict_data   <= d;
      cache_evict_byteen <= be;
      cache_evict_last   <= last;
      ctrl_evict_ready   <= (nstall == 0);
      for (int i = 0; i < nstall; i++) begin
         @(posedge clk);
         if (change && i == 0) cache_evict_data <= d ^ 64'h1;
         ctrl_evict_ready <= (i == nstall - 1);
      end
      @(posedge clk);
      cache_evict_valid <= 1'b0;
      ctrl_evict_ready  <= 1'b0;
      log_event(EV_BEAT, '0, (change && nstall > 0) ? d ^ 64'h1 : d, be, last,
                change && nstall > 0);
   endtask

   task automatic run_burst(input logic [CLS_W-1:0] cls, input logic [1:0] len);
      logic [DATA_W-1:0] d [LINE_BEATS];
      logic [BE_W-1:0]   b [LINE_BEATS];
      int                n;
      n = (cls == CLS_EVICTION) ? LINE_BEATS : int'(len) + 1;
      for (int i = 0; i < n; i++) begin
         d[i] = {$random(seed), $random(seed)};
         b[i] = (cls == CLS_BYPASS_ONLY) ? BE_W'($random(seed)) : '1;
      end
      if (cls == CLS_BYPASS_ONLY) begin
         for (int i = 0; i < n; i++) send_wr(d[i], b[i], i == n - 1);
      end
      for (int i = 0; i < n; i++) begin
         send_beat(d[i], b[i], i == n - 1, $unsigned($random(seed)) % 3, 1'b0);
      end
   endtask

   task automatic run_check();
      -> test_end;
      @(check_done);
   endtask

   initial begin
      logic [1:0] len;
      int         pick;
      seed = 6839;
      cycle_cnt = 0;
      reset_n = 1'b0;
      {cache_valid_p2, cache_evict_valid_p2, ctrl_op_read_data_p2, ctrl_op_write_data_p2} = '0;
      {ctrl_op_port_sel_p2, ctrl_op_bypass_p2, ctrl_op_allocate_p2} = '0;
      ctrl_op_burst_len_p2 = '0;
      {cache_nack_p2, cache_nack_uce_p2, cache_nack_ce_p2, cache_nack_no_allocate_p2} = '0;
      {ctrl_wr_valid, ctrl_wr_last, ctrl_wr_data, ctrl_wr_byte_en} = '0;
      cache_wr_ready = 1'b1;
      ctrl_wr_bypass = 1'b1;
      {cache_evict_valid, ctrl_evict_ready, cache_evict_last} = '0;
      cache_evict_data = '0;
      cache_evict_byteen = '0;

      // legal traffic of every class
      apply_reset();
      for (int r = 0; r < 12; r++) begin
         len  = BURST_LEN_W'($random(seed));
         pick = $unsigned($random(seed)) % 6;
         case (pick)
            0: begin
               send_cmd(CMD_EVICT, len);
               run_burst(CLS_EVICTION, len);
            end
            1: begin
               send_cmd(CMD_DOUBLE, len);
               run_burst(CLS_EVICTION, len);
               run_burst(CLS_BYPASS_ONLY, len);
            end
            2: begin
               send_cmd(CMD_WT, len);
               run_burst(CLS_WR_THROUGH, len);
            end
            3: begin
               send_cmd(CMD_BYP, len);
               run_burst(CLS_BYPASS_ONLY, len);
            end
            4: begin
               send_cmd(CMD_RD, len);
               run_burst(CLS_RD_ONLY, len);
            end
            default: send_cmd(CMD_RD | (13'h4 << ($unsigned($random(seed)) % 4)), len);
         endcase
      end
      run_check();

      // early last on a read
      apply_reset();
      send_cmd(CMD_RD, 2'd2);
      send_beat(64'h11, '1, 1'b0, 0, 1'b0);
      send_beat(64'h12, '1, 1'b1, 1, 1'b0);
      run_check();

      // missing last on an eviction
      apply_reset();
      send_cmd(CMD_EVICT, 2'd0);
      for (int i = 0; i < LINE_BEATS; i++) send_beat(64'h20 + i, '1, 1'b0, 0, 1'b0);
      run_check();

      apply_reset();
      send_cmd(CMD_WT, 2'd0);
      send_beat(64'h33, 8'hfe, 1'b1, 0, 1'b0);
      run_check();

      // bad bypass data
      apply_reset();
      send_cmd(CMD_BYP, 2'd0);
      send_wr(64'h0123_4567_89ab_cdef, 8'h0f, 1'b1);
      send_beat(64'h0123_4567_89ab_cdee, 8'h0f, 1'b1, 0, 1'b0);
      run_check();

      // bypass beat with nothing captured
      apply_reset();
      send_cmd(CMD_BYP, 2'd0);
      send_beat(64'h55, 8'hff, 1'b1, 0, 1'b0);
      run_check();

      apply_reset();
      send_cmd(CMD_RD, 2'd0);
      send_beat(64'h66, '1, 1'b1, 2, 1'b1);
      run_check();

      apply_reset();
      send_beat(64'h77, '1, 1'b1, 0, 1'b0);
      run_check();

      apply_reset();
      for (int i = 0; i <= CMD_DEPTH; i++) send_cmd(CMD_RD, 2'd0);
      run_check();

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- evict_mon_top.f
hw/evict_cmd_pkg.sv
hw/evict_err_pkg.sv
hw/evict_cmd_decode.sv
hw/evict_cmd_queue.sv
hw/evict_beat_tracker.sv
hw/evict_bypass_buffer.sv
hw/evict_mon_top.sv
dv/evict_mon_chk.sv
dv/evict_mon_tb.sv

//--- hw/evict_beat_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module evict_beat_tracker import evict_cmd_pkg::*, evict_err_pkg::*; #(
   parameter int DATA_W      = 64,
   parameter int BURST_LEN_W = 2
) (
   input  wire                    clk,
   input  wire                    reset_n,
   input  wire                    cache_evict_valid,
   input  wire                    ctrl_evict_ready,
   input  wire  [DATA_W-1:0]      cache_evict_data,
   input  wire  [DATA_W/8-1:0]    cache_evict_byteen,
   input  wire                    cache_evict_last,
   input  wire  [CLS_W-1:0]       head_cls,
   input  wire  [BURST_LEN_W-1:0] head_burst_len,
   input  wire                    empty,
   output logic                   pop,
   output logic                   bypass_beat,
   output logic                   err_last,
   output logic                   err_byteen,
   output logic                   err_hold,
   output logic                   err_underflow
);

   localparam int BEAT_W = (BURST_LEN_W > $clog2(LINE_BEATS)) ? BURST_LEN_W :
                           $clog2(LINE_BEATS);

   logic [BEAT_W-1:0]   beat_cnt_q;
   logic [BEAT_W-1:0]   last_idx;
   logic                xfer;
   logic                head_xfer;
   logic                final_beat;
   logic                full_byteen_cls;
   logic                stall_q;
   logic [DATA_W-1:0]   held_data;
   logic [DATA_W/8-1:0] held_byteen;
   logic                held_last;
   logic [ERR_N-1:0]    err_set;
   logic [ERR_N-1:0]    err_q;

   assign xfer      = cache_evict_valid & ctrl_evict_ready;
   assign head_xfer = xfer & ~empty;

   // evictions always move a whole line, the rest follow the burst length
   assign last_idx   = (head_cls == CLS_EVICTION) ? BEAT_W'(LINE_BEATS - 1) :
                       BEAT_W'(head_burst_len);
   assign final_beat = (beat_cnt_q == last_idx);

   assign full_byteen_cls = (head_cls == CLS_EVICTION) || (head_cls == CLS_RD_ONLY) ||
                            (head_cls == CLS_WR_THROUGH);

   // an early last also retires the entry so later commands stay aligned
   assign pop         = head_xfer & (final_beat | cache_evict_last);
   assign bypass_beat = head_xfer & (head_cls == CLS_BYPASS_ONLY);

   always_comb begin
      err_set = '0;
      err_set[ERR_LAST]      = head_xfer & (cache_evict_last != final_beat);
      err_set[ERR_BYTEEN]    = head_xfer & full_byteen_cls & ~(&cache_evict_byteen);
      err_set[ERR_UNDERFLOW] = xfer & empty;
      // stalled beat must come back unchanged
      err_set[ERR_HOLD]      = stall_q & (~cache_evict_valid |
                                          (cache_evict_data != held_data) |
                                          (cache_evict_byteen != held_byteen) |
                                          (cache_evict_last != held_last));
   end

   always_ff @(posedge clk) begin
      held_data   <= cache_evict_data;
      held_byteen <= cache_evict_byteen;
      held_last   <= cache_evict_last;
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         beat_cnt_q <= '0;
         stall_q    <= 1'b0;
         err_q      <= '0;
      end else begin
         if (pop) begin
            beat_cnt_q <= '0;
         end else if (head_xfer) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
         stall_q <= cache_evict_valid & ~ctrl_evict_ready;
         err_q   <= err_q | err_set;
      end
   end

   assign err_last      = err_q[ERR_LAST];
   assign err_byteen    = err_q[ERR_BYTEEN];
   assign err_hold      = err_q[ERR_HOLD];
   assign err_underflow = err_q[ERR_UNDERFLOW];

endmodule

`default_nettype wire

//--- hw/evict_bypass_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module evict_bypass_buffer import evict_err_pkg::*; #(
   parameter int DATA_W    = 64,
   parameter int BYP_DEPTH = 4
) (
   input  wire                 clk,
   input  wire                 reset_n,
   input  wire                 ctrl_wr_valid,
   input  wire                 cache_wr_ready,
   input  wire                 ctrl_wr_bypass,
   input  wire  [DATA_W-1:0]   ctrl_wr_data,
   input  wire  [DATA_W/8-1:0] ctrl_wr_byte_en,
   input  wire                 ctrl_wr_last,
   input  wire                 bypass_beat,
   input  wire  [DATA_W-1:0]   cache_evict_data,
   input  wire  [DATA_W/8-1:0] cache_evict_byteen,
   input  wire                 cache_evict_last,
   output logic                err_bypass
);

   localparam int WORD_W = DATA_W + DATA_W/8 + 1;
   localparam int PTR_W  = (BYP_DEPTH > 1) ? $clog2(BYP_DEPTH) : 1;
   localparam int CNT_W  = $clog2(BYP_DEPTH + 1);

   logic [WORD_W-1:0] mem [BYP_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              push;
   logic              pop;
   logic              buf_empty;
   logic [ERR_N-1:0]  err_set;
   logic [ERR_N-1:0]  err_q;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(BYP_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign buf_empty = (count_q == '0);
   // beats that arrive while the buffer is full are dropped
   assign push = ctrl_wr_valid & cache_wr_ready & ctrl_wr_bypass & (count_q < BYP_DEPTH);
   assign pop  = bypass_beat & ~buf_empty;

   always_comb begin
      err_set = '0;
      err_set[ERR_BYPASS] = bypass_beat &
         (buf_empty | (mem[rd_ptr_q] != {cache_evict_data, cache_evict_byteen, cache_evict_last}));
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= {ctrl_wr_data, ctrl_wr_byte_en, ctrl_wr_last};
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         err_q    <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
         err_q   <= err_q | err_set;
      end
   end

   assign err_bypass = err_q[ERR_BYPASS];

endmodule

`default_nettype wire

//--- hw/evict_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module evict_cmd_decode import evict_cmd_pkg::*; #(
   parameter int BURST_LEN_W = 2
) (
   input  wire                   cache_valid_p2,
   input  wire                   cache_evict_valid_p2,
   input  wire                   ctrl_op_read_data_p2,
   input  wire                   ctrl_op_write_data_p2,
   input  wire                   ctrl_op_port_sel_p2,
   input  wire                   ctrl_op_bypass_p2,
   input  wire                   ctrl_op_allocate_p2,
   input  wire [BURST_LEN_W-1:0] ctrl_op_burst_len_p2,
   input  wire                   cache_nack_p2,
   input  wire                   cache_nack_uce_p2,
   input  wire                   cache_nack_ce_p2,
   input  wire                   cache_nack_no_allocate_p2,
   output logic                  push_1,
   output logic [CLS_W-1:0]      entry_1_cls,
   output logic                  push_2,
   output logic [CLS_W-1:0]      entry_2_cls,
   output logic [BURST_LEN_W-1:0] entry_burst_len
);

   logic live;
   logic is_eviction;
   logic is_double;
   logic is_wr_through;
   logic is_byp_only;
   logic is_rd_only;

   // a nacked command never reaches the evict port
   assign live = cache_valid_p2 & ~cache_nack_p2 & ~cache_nack_uce_p2 & ~cache_nack_ce_p2 &
                 ~(cache_nack_no_allocate_p2 & ctrl_op_allocate_p2);

   assign is_eviction   = ctrl_op_read_data_p2 & cache_evict_valid_p2;
   // eviction plus bypass read data, two separate transfers
   assign is_double     = is_eviction & ~ctrl_op_write_data_p2 & ctrl_op_port_sel_p2 &
                          ctrl_op_bypass_p2;
   assign is_wr_through = ~ctrl_op_read_data_p2 & ctrl_op_write_data_p2 &
                          ctrl_op_port_sel_p2 & ctrl_op_bypass_p2;
   assign is_byp_only   = ~ctrl_op_read_data_p2 & ~ctrl_op_write_data_p2 &
                          ctrl_op_port_sel_p2 & ctrl_op_bypass_p2;
   assign is_rd_only    = ctrl_op_read_data_p2 & ~ctrl_op_write_data_p2 &
                          ctrl_op_port_sel_p2 & ~ctrl_op_bypass_p2 & ~cache_evict_valid_p2;

   always_comb begin
      entry_1_cls = CLS_NONE;
      if (is_eviction) begin
         entry_1_cls = CLS_EVICTION;
      end else if (is_wr_through) begin
         entry_1_cls = CLS_WR_THROUGH;
      end else if (is_byp_only) begin
         entry_1_cls = CLS_BYPASS_ONLY;
      end else if (is_rd_only) begin
         entry_1_cls = CLS_RD_ONLY;
      end
   end

   assign push_1          = live & (entry_1_cls != CLS_NONE);
   assign push_2          = live & is_double;
   assign entry_2_cls     = is_double ? CLS_BYPASS_ONLY : CLS_NONE;
   assign entry_burst_len = ctrl_op_burst_len_p2;

endmodule

`default_nettype wire

//--- hw/evict_cmd_pkg.sv
`default_nettype none

package evict_cmd_pkg;

   // width of the evict class code held in each command entry
   localparam int CLS_W = 3;

   // evict class codes
   localparam logic [CLS_W-1:0] CLS_NONE        = 3'd0;
   localparam logic [CLS_W-1:0] CLS_EVICTION    = 3'd1;
   localparam logic [CLS_W-1:0] CLS_RD_ONLY     = 3'd2;
   localparam logic [CLS_W-1:0] CLS_WR_THROUGH  = 3'd3;
   localparam logic [CLS_W-1:0] CLS_BYPASS_ONLY = 3'd4;

   // a full line eviction always moves this many beats
   localparam int LINE_BEATS = 4;

endpackage

`default_nettype wire

//--- hw/evict_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module evict_cmd_queue import evict_cmd_pkg::*, evict_err_pkg::*; #(
   parameter int BURST_LEN_W = 2,
   parameter int CMD_DEPTH   = 8
) (
   input  wire                    clk,
   input  wire                    reset_n,
   input  wire                    push_1,
   input  wire  [CLS_W-1:0]       entry_1_cls,
   input  wire                    push_2,
   input  wire  [CLS_W-1:0]       entry_2_cls,
   input  wire  [BURST_LEN_W-1:0] entry_burst_len,
   input  wire                    pop,
   output logic [CLS_W-1:0]       head_cls,
   output logic [BURST_LEN_W-1:0] head_burst_len,
   output logic                   empty,
   output logic                   err_overflow
);

   localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNT_W = $clog2(CMD_DEPTH + 1);

   logic [CLS_W-1:0]       cls_mem [CMD_DEPTH];
   logic [BURST_LEN_W-1:0] len_mem [CMD_DEPTH];
   logic [PTR_W-1:0]       wr_ptr_q;
   logic [PTR_W-1:0]       rd_ptr_q;
   logic [PTR_W-1:0]       wr_slot_2;
   logic [CNT_W-1:0]       count_q;
   logic                   accept_1;
   logic                   accept_2;
   logic                   pop_ok;
   logic [ERR_N-1:0]       err_set;
   logic [ERR_N-1:0]       err_q;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // second entry only gets the slot left after the first one
   assign accept_1  = push_1 & (count_q < CMD_DEPTH);
   assign accept_2  = push_2 & ((count_q + CNT_W'(accept_1)) < CMD_DEPTH);
   assign wr_slot_2 = accept_1 ? next_ptr(wr_ptr_q) : wr_ptr_q;
   assign pop_ok    = pop & ~empty;

   always_comb begin
      err_set = '0;
      err_set[ERR_OVERFLOW] = (push_1 & ~accept_1) | (push_2 & ~accept_2);
   end

   always_ff @(posedge clk) begin
      if (accept_1) begin
         cls_mem[wr_ptr_q] <= entry_1_cls;
         len_mem[wr_ptr_q] <= entry_burst_len;
      end
      if (accept_2) begin
         cls_mem[wr_slot_2] <= entry_2_cls;
         len_mem[wr_slot_2] <= entry_burst_len;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         err_q    <= '0;
      end else begin
         if (accept_2) begin
            wr_ptr_q <= next_ptr(wr_slot_2);
         end else if (accept_1) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop_ok) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(accept_1) + CNT_W'(accept_2) - CNT_W'(pop_ok);
         err_q   <= err_q | err_set;
      end
   end

   assign head_cls       = cls_mem[rd_ptr_q];
   assign head_burst_len = len_mem[rd_ptr_q];
   assign empty          = (count_q == '0);
   assign err_overflow   = err_q[ERR_OVERFLOW];

endmodule

`default_nettype wire

//--- hw/evict_err_pkg.sv
`default_nettype none

package evict_err_pkg;

   localparam int ERR_N = 6;

   // bit positions in err_flags
   localparam int ERR_LAST      = 0;
   localparam int ERR_BYTEEN    = 1;
   localparam int ERR_BYPASS    = 2;
   localparam int ERR_HOLD      = 3;
   localparam int ERR_UNDERFLOW = 4;
   localparam int ERR_OVERFLOW  = 5;

endpackage

`default_nettype wire

//--- hw/evict_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module evict_mon_top import evict_cmd_pkg::*, evict_err_pkg::*; #(
   parameter int DATA_W      = 64,
   parameter int BURST_LEN_W = 2,
   parameter int CMD_DEPTH   = 8,
   parameter int BYP_DEPTH   = 4
) (
   input  wire                   clk,
   input  wire                   reset_n,
   input  wire                   cache_valid_p2,
   input  wire                   cache_evict_valid_p2,
   input  wire                   ctrl_op_read_data_p2,
   input  wire                   ctrl_op_write_data_p2,
   input  wire                   ctrl_op_port_sel_p2,
   input  wire                   ctrl_op_bypass_p2,
   input  wire                   ctrl_op_allocate_p2,
   input  wire [BURST_LEN_W-1:0] ctrl_op_burst_len_p2,
   input  wire                   cache_nack_p2,
   input  wire                   cache_nack_uce_p2,
   input  wire                   cache_nack_ce_p2,
   input  wire                   cache_nack_no_allocate_p2,
   input  wire                   ctrl_wr_valid,
   input  wire                   cache_wr_ready,
   input  wire [DATA_W-1:0]      ctrl_wr_data,
   input  wire [DATA_W/8-1:0]    ctrl_wr_byte_en,
   input  wire                   ctrl_wr_last,
   input  wire                   ctrl_wr_bypass,
   input  wire                   cache_evict_valid,
   input  wire                   ctrl_evict_ready,
   input  wire [DATA_W-1:0]      cache_evict_data,
   input  wire [DATA_W/8-1:0]    cache_evict_byteen,
   input  wire                   cache_evict_last,
   output logic [ERR_N-1:0]      err_flags
);

   logic                   push_1;
   logic                   push_2;
   logic [CLS_W-1:0]       entry_1_cls;
   logic [CLS_W-1:0]       entry_2_cls;
   logic [BURST_LEN_W-1:0] entry_burst_len;
   logic [CLS_W-1:0]       head_cls;
   logic [BURST_LEN_W-1:0] head_burst_len;
   logic                   empty;
   logic                   pop;
   logic                   bypass_beat;
   logic                   err_last;
   logic                   err_byteen;
   logic                   err_bypass;
   logic                   err_hold;
   logic                   err_underflow;
   logic                   err_overflow;

   evict_cmd_decode #(.BURST_LEN_W(BURST_LEN_W)) u_decode (.*);

   evict_cmd_queue #(
      .BURST_LEN_W(BURST_LEN_W),
      .CMD_DEPTH  (CMD_DEPTH)
   ) u_queue (.*);

   evict_beat_tracker #(
      .DATA_W     (DATA_W),
      .BURST_LEN_W(BURST_LEN_W)
   ) u_tracker (.*);

   evict_bypass_buffer #(
      .DATA_W   (DATA_W),
      .BYP_DEPTH(BYP_DEPTH)
   ) u_bypass (.*);

   // each block owns its own flag bits
   always_comb begin
      err_flags = '0;
      err_flags[ERR_LAST]      = err_last;
      err_flags[ERR_BYTEEN]    = err_byteen;
      err_flags[ERR_BYPASS]    = err_bypass;
      err_flags[ERR_HOLD]      = err_hold;
      err_flags[ERR_UNDERFLOW] = err_underflow;
      err_flags[ERR_OVERFLOW]  = err_overflow;
   end

endmodule

`default_nettype wire
